// ==== bench/tdc_sva.sv ====
`default_nettype none
`timescale 1ns/100ps

module tdc_sva (
    input wire logic              clk,
    input wire logic              rst_n,
    input wire logic              valid_i,
    input wire logic              ready_i,
    input wire logic              last_i,
    input wire tdc_pkg::tof_t     data_i,
    input wire tdc_pkg::int_t     int_i,
    input wire tdc_pkg::hit_idx_t num_i,
    input wire logic              busy_i
);

    // ----------------------------------------
    // output handshake
    property hold_while_stalled;
        @(posedge clk) disable iff (!rst_n)
            (valid_i && !ready_i) |=> (valid_i && $stable(data_i) && $stable(int_i)
                                       && $stable(num_i) && $stable(last_i));
    endproperty

    property last_needs_valid;
        @(posedge clk) disable iff (!rst_n) last_i |-> valid_i;
    endproperty

    property idle_after_reset;
        @(posedge clk) (!rst_n || $rose(rst_n)) |-> (!busy_i && !valid_i && !last_i);
    endproperty

    a_hold : assert property (hold_while_stalled) else $error("beat changed while stalled");
    a_last : assert property (last_needs_valid) else $error("last without valid");
    a_idle : assert property (idle_after_reset) else $error("busy or valid set after reset");

endmodule

bind tdc_top tdc_sva sva_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .valid_i (out_valid_o),
    .ready_i (out_ready_i),
    .last_i  (out_last_o),
    .data_i  (out_data_o),
    .int_i   (out_int_o),
    .num_i   (out_num_o),
    .busy_i  (busy_o)
);

`default_nettype wire

// ==== bench/tdc_tb.sv ====
`default_nettype none
`timescale 1ns/100ps

module tdc_tb;
    import tdc_pkg::*;

    localparam int N_ROWS = 8;

    logic clk, rst_n, tdc_start_i, tdc_trigger_i, out_ready_i;
    phase_t start_code_i, stop_code_i;
    tof_t range_i, out_data_o;
    logic [15:0] spad_mask_i;
    int_t out_int_o;
    hit_idx_t out_num_o;
    logic out_last_o, out_valid_o, busy_o;

    logic [31:0] lfsr_q = 32'h8cb6_bc63;

    // ----------------------------------------
    // stimulus table with random columns filled at start
    string name_tab [N_ROWS] = '{"no_hit", "one_hit", "two_hits", "three_hits",
                                 "fourth_ignored", "late_ignored", "zero_range",
                                 "ready_stalls"};
    int lim_tab [N_ROWS]     = '{5, 8, 10, 12, 9, 6, 0, 14};   // range upper bits
    int ntrig_tab [N_ROWS]   = '{0, 1, 2, 3, 4, 3, 1, 3};
    int off_tab [N_ROWS][4]  = '{'{0, 0, 0, 0}, '{3, 0, 0, 0}, '{0, 9, 0, 0},
                                 '{2, 5, 7, 0}, '{1, 2, 4, 6}, '{1, 6, 8, 0},
                                 '{0, 0, 0, 0}, '{4, 5, 13, 0}};
    int restart_tab [N_ROWS] = '{-1, -1, -1, -1, -1, 3, -1, 1};   // start while busy
    tof_t        range_tab [N_ROWS];
    phase_t      start_tab [N_ROWS];
    phase_t      stop_tab [N_ROWS][4];
    logic [15:0] mask_tab [N_ROWS][4];
    logic [15:0] ready_tab [N_ROWS];

    tof_t exp_tof [3];
    int_t exp_int [3];
    int   exp_n;

    tdc_top #(.N_HITS(MAX_HITS)) tdc_top_i (
        .clk(clk), .rst_n(rst_n), .tdc_start_i(tdc_start_i), .start_code_i(start_code_i),
        .range_i(range_i), .tdc_trigger_i(tdc_trigger_i), .stop_code_i(stop_code_i),
        .spad_mask_i(spad_mask_i), .out_data_o(out_data_o), .out_int_o(out_int_o),
        .out_num_o(out_num_o), .out_last_o(out_last_o), .out_valid_o(out_valid_o),
        .out_ready_i(out_ready_i), .busy_o(busy_o)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // galois lfsr stepped once per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr_q[0]};
            lfsr_q = (lfsr_q >> 1) ^ (lfsr_q[0] ? 32'h8020_0003 : 32'h0);
        end
        return r;
    endfunction

    function automatic phase_t therm_code(input int n);
        return phase_t'((32'h1 << n) - 1);
    endfunction

    function automatic int fine_units(input phase_t code);
        int f;
        f = 2 * $countones(code);
        return (f > 31) ? 31 : f;
    endfunction

    function automatic int_t mask_level(input logic [15:0] mask);
        int n;
        n = $countones(mask);
        return int_t'((n > 15) ? 15 : n);
    endfunction

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("TESTBENCH FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string test, input string field,
                               input int exp_v, input int act_v);
        assert (exp_v == act_v) else
            stop_run($sformatf("** Error %s %s expected %0h actual %0h",
                               test, field, exp_v, act_v));
    endtask

    task automatic fill_table();
        for (int r = 0; r < N_ROWS; r++) begin
            range_tab[r] = tof_t'(lim_tab[r] * 32 + int'(rand_bits(5)));
            start_tab[r] = therm_code(int'(rand_bits(5)) % 17);
            for (int t = 0; t < 4; t++) begin
                stop_tab[r][t] = therm_code(int'(rand_bits(5)) % 17);
                mask_tab[r][t] = 16'(rand_bits(16));
            end
            ready_tab[r] = 16'(rand_bits(16)) | 16'h0001;
        end
        ready_tab[7] = (ready_tab[7] & 16'(rand_bits(16))) | 16'h0001;   // long stalls
    endtask

    // keeps the first three hits inside the window in order
    task automatic build_expected(input int r);
        int off;
        exp_n = 0;
        for (int t = 0; t < ntrig_tab[r]; t++) begin
            off = off_tab[r][t];
            if (off < lim_tab[r] && exp_n < MAX_HITS) begin
                exp_tof[exp_n] = tof_t'(off * 32 + fine_units(stop_tab[r][t])
                                        - fine_units(start_tab[r]));
                exp_int[exp_n] = mask_level(mask_tab[r][t]);
                exp_n++;
            end
        end
    endtask

    task automatic run_row(input int r);
        int k, span, beats, n_beats, cyc;
        build_expected(r);
        n_beats = (exp_n == 0) ? 1 : exp_n;
        span = lim_tab[r] + 1;
        for (int t = 0; t < ntrig_tab[r]; t++) begin
            if (off_tab[r][t] + 1 > span) span = off_tab[r][t] + 1;
        end
        assert (!busy_o) else stop_run("busy_o is high before the start strobe");
        @(posedge clk);
        tdc_start_i  <= 1'b1;
        start_code_i <= start_tab[r];
        range_i      <= range_tab[r];
        // value driven in cycle c is sampled with counter == c
        for (int c = 0; c <= span; c++) begin
            @(posedge clk);
            k = -1;
            for (int t = 0; t < ntrig_tab[r]; t++) begin
                if (off_tab[r][t] == c) k = t;
            end
            tdc_trigger_i <= (k >= 0);
            stop_code_i   <= (k >= 0) ? stop_tab[r][k] : phase_t'(rand_bits(16));
            spad_mask_i   <= (k >= 0) ? mask_tab[r][k] : 16'(rand_bits(16));
            tdc_start_i   <= (c == restart_tab[r]);
            if (c == restart_tab[r]) begin
                range_i      <= tof_t'(40 * 32 + int'(rand_bits(5)));
                start_code_i <= phase_t'(rand_bits(16));
            end
        end
        @(posedge clk);
        tdc_trigger_i <= 1'b0;
        tdc_start_i   <= 1'b0;
        // ----------------------------------------
        // output burst
        beats = 0;
        cyc = 0;
        while (beats < n_beats) begin
            if (cyc > 300) stop_run($sformatf("%s: output beat never came", name_tab[r]));
            @(posedge clk);
            out_ready_i <= ready_tab[r][cyc % 16];
            cyc++;
            @(negedge clk);
            if (out_valid_o && out_ready_i) begin
                assert (busy_o) else
                    stop_run($sformatf("%s: busy_o fell before the last beat", name_tab[r]));
                check_value(name_tab[r], "data", (exp_n == 0) ? NO_HIT_TOF : exp_tof[beats],
                            out_data_o);
                check_value(name_tab[r], "intensity", (exp_n == 0) ? 0 : exp_int[beats],
                            out_int_o);
                check_value(name_tab[r], "num", exp_n, out_num_o);
                check_value(name_tab[r], "last", beats == n_beats - 1, out_last_o);
                beats++;
            end
        end
        @(posedge clk);
        out_ready_i <= 1'b0;
        cyc = 0;
        @(negedge clk);
        while (busy_o) begin
            if (cyc == 20) stop_run($sformatf("%s: busy_o stuck high", name_tab[r]));
            @(negedge clk);
            cyc++;
        end
        assert (!out_valid_o) else stop_run("out_valid_o still high after the last beat");
    endtask

    initial begin
        rst_n         <= 1'b0;
        tdc_start_i   <= 1'b0;
        start_code_i  <= '0;
        range_i       <= '0;
        tdc_trigger_i <= 1'b0;
        stop_code_i   <= '0;
        spad_mask_i   <= '0;
        out_ready_i   <= 1'b0;
        fill_table();
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        for (int r = 0; r < N_ROWS; r++) begin
            run_row(r);
        end
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== flist.f ====
rtl/tdc_pkg.sv
rtl/tdc_hit_if.sv
rtl/tdc_res_if.sv
rtl/tdc_hit_capture.sv
rtl/tdc_tof_calc.sv
rtl/tdc_burst_out.sv
rtl/tdc_top.sv
bench/tdc_sva.sv
bench/tdc_tb.sv

// ==== rtl/tdc_burst_out.sv ====
`default_nettype none
`timescale 1ns/100ps

module tdc_burst_out #(
    parameter int N_HITS = tdc_pkg::MAX_HITS
) (
    input  wire logic         clk,
    input  wire logic         rst_n,
    tdc_res_if.result         res,
    output tdc_pkg::tof_t     out_data_o,
    output tdc_pkg::int_t     out_int_o,
    output tdc_pkg::hit_idx_t out_num_o,
    output logic              out_last_o,
    output logic              out_valid_o,
    input  wire logic         out_ready_i
);
    import tdc_pkg::*;

    typedef enum logic {S_IDLE, S_SEND} state_t;

    state_t   state;
    hit_idx_t beat;
    hit_idx_t nxt;
    logic     accept;
    logic     load;
    tof_t     tof_mem [N_HITS];
    int_t     int_mem [N_HITS];

    assign accept         = out_valid_o && out_ready_i;
    assign load           = (state == S_IDLE) && res.res_ready;
    assign nxt            = beat + 1'b1;
    assign res.burst_done = accept && out_last_o;

    // result slots
    always_ff @(posedge clk) begin
        if (res.res_valid) begin
            tof_mem[res.res_idx] <= res.res_tof;
            int_mem[res.res_idx] <= res.res_int;
        end
    end

    // ----------------------------------------
    // burst FSM
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= S_IDLE;
            beat        <= '0;
            out_valid_o <= 1'b0;
            out_last_o  <= 1'b0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (res.res_ready) begin
                        state       <= S_SEND;
                        beat        <= '0;
                        out_valid_o <= 1'b1;
                        out_last_o  <= (res.res_count <= 2'd1);   // 0 or 1 hit
                    end
                end
                S_SEND: begin
                    if (accept) begin
                        if (out_last_o) begin
                            state       <= S_IDLE;
                            out_valid_o <= 1'b0;
                            out_last_o  <= 1'b0;
                        end else begin
                            beat       <= nxt;
                            out_last_o <= (nxt == out_num_o - 1'b1);
                        end
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // beat payload, held until accepted
    always_ff @(posedge clk) begin
        if (load) begin
            out_num_o  <= res.res_count;
            out_data_o <= (res.res_count == '0) ? NO_HIT_TOF : tof_mem[0];
            out_int_o  <= (res.res_count == '0) ? '0 : int_mem[0];
        end else if ((state == S_SEND) && accept && !out_last_o) begin
            out_data_o <= tof_mem[nxt];
            out_int_o  <= int_mem[nxt];
        end
    end

endmodule

`default_nettype wire

// ==== rtl/tdc_hit_capture.sv ====
`default_nettype none
`timescale 1ns/100ps

module tdc_hit_capture #(
    parameter int N_HITS = tdc_pkg::MAX_HITS
) (
    input  wire logic            clk,
    input  wire logic            rst_n,
    input  wire logic            tdc_start_i,
    input  wire tdc_pkg::phase_t start_code_i,
    input  wire tdc_pkg::tof_t   range_i,
    input  wire logic            tdc_trigger_i,
    input  wire tdc_pkg::phase_t stop_code_i,
    input  wire logic [15:0]     spad_mask_i,
    input  wire logic            burst_done_i,
    output logic                 busy_o,
    tdc_hit_if.capture           hit
);
    import tdc_pkg::*;

    localparam hit_idx_t HIT_MAX = hit_idx_t'(N_HITS);

    tof_t     range_q;
    coarse_t  counter;
    logic     win_open;
    hit_idx_t hit_cnt;
    logic     start_ok;
    logic     at_limit;
    logic     hit_ok;

    assign start_ok = tdc_start_i && !busy_o;   // starts while busy are dropped
    assign at_limit = win_open && (counter == range_q[TOF_W-1:FINE_W]);
    assign hit_ok   = tdc_trigger_i && win_open && !at_limit && (hit_cnt < HIT_MAX);

    assign hit.window_done = at_limit;
    assign hit.hit_count   = hit_cnt;

    // ----------------------------------------
    // window and busy control
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_o   <= 1'b0;
            win_open <= 1'b0;
            counter  <= '0;
            hit_cnt  <= '0;
        end else if (start_ok) begin
            busy_o   <= 1'b1;
            win_open <= 1'b1;
            counter  <= '0;
            hit_cnt  <= '0;
        end else begin
            if (burst_done_i) begin
                busy_o <= 1'b0;
            end
            if (at_limit) begin
                win_open <= 1'b0;
            end else if (win_open) begin
                counter <= counter + 1'b1;
            end
            if (hit_ok) begin
                hit_cnt <= hit_cnt + 1'b1;
            end
        end
    end

    // ----------------------------------------
    // start and hit registers
    always_ff @(posedge clk) begin
        if (start_ok) begin
            range_q        <= range_i;
            hit.start_code <= start_code_i;
        end
        if (hit_ok) begin
            // arrival order, slot = current count
            hit.hit_coarse[hit_cnt] <= counter;
            hit.hit_code[hit_cnt]   <= stop_code_i;
            hit.hit_mask[hit_cnt]   <= spad_mask_i;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/tdc_hit_if.sv ====
`default_nettype none
`timescale 1ns/100ps

interface tdc_hit_if #(
    parameter int N_HITS = tdc_pkg::MAX_HITS
) ();
    import tdc_pkg::*;

    phase_t      start_code;
    coarse_t     hit_coarse [N_HITS];
    phase_t      hit_code   [N_HITS];   // stop phase per hit
    logic [15:0] hit_mask   [N_HITS];   // spad enables at trigger
    hit_idx_t    hit_count;
    logic        window_done;           // one cycle, count is final here

    modport capture (
        output start_code, hit_coarse, hit_code, hit_mask, hit_count, window_done
    );

    modport calc (
        input  start_code, hit_coarse, hit_code, hit_mask, hit_count, window_done
    );

endinterface

`default_nettype wire

// ==== rtl/tdc_pkg.sv ====
`default_nettype none

package tdc_pkg;

    // ----------------------------------------
    // widths
    localparam int PHASE_W   = 16;                 // thermometer phase code
    localparam int COARSE_W  = 10;
    localparam int FINE_W    = 5;                  // 32 fine units per coarse cycle
    localparam int TOF_W     = COARSE_W + FINE_W;
    localparam int INT_W     = 4;

    // ----------------------------------------
    // limits
    localparam int MAX_HITS  = 3;
    localparam int HIT_IDX_W = 2;                  // holds 0..MAX_HITS

    typedef logic [PHASE_W-1:0]   phase_t;
    typedef logic [COARSE_W-1:0]  coarse_t;
    typedef logic [TOF_W-1:0]     tof_t;
    typedef logic [INT_W-1:0]     int_t;
    typedef logic [HIT_IDX_W-1:0] hit_idx_t;

    // data word of the single beat sent for an empty window
    localparam tof_t NO_HIT_TOF = '1;

endpackage

`default_nettype wire

// ==== rtl/tdc_res_if.sv ====
`default_nettype none
`timescale 1ns/100ps

interface tdc_res_if ();
    import tdc_pkg::*;

    logic     res_valid;    // one pulse per computed hit
    hit_idx_t res_idx;
    tof_t     res_tof;
    int_t     res_int;
    hit_idx_t res_count;
    logic     res_ready;    // all results stored
    logic     burst_done;   // last beat accepted

    modport calc (
        output res_valid, res_idx, res_tof, res_int, res_count, res_ready
    );

    modport result (
        input  res_valid, res_idx, res_tof, res_int, res_count, res_ready,
        output burst_done
    );

endinterface

`default_nettype wire

// ==== rtl/tdc_tof_calc.sv ====
`default_nettype none
`timescale 1ns/100ps

module tdc_tof_calc #(
    parameter int N_HITS = tdc_pkg::MAX_HITS
) (
    input  wire logic clk,
    input  wire logic rst_n,
    tdc_hit_if.calc   hit,
    tdc_res_if.calc   res
);
    import tdc_pkg::*;

    localparam hit_idx_t LAST_SLOT = hit_idx_t'(N_HITS - 1);

    logic              run;
    hit_idx_t          idx;        // next hit while running
    hit_idx_t          sel;
    logic              step;
    logic              is_last;
    logic              last_q;
    logic [FINE_W-1:0] fine_start;
    logic [FINE_W-1:0] fine_stop;
    tof_t              tof_c;
    int_t              int_c;

    function automatic logic [4:0] ones16(input logic [15:0] v);
        logic [4:0] n;
        n = '0;
        for (int i = 0; i < 16; i++) begin
            n = n + {4'b0, v[i]};
        end
        return n;
    endfunction

    // two fine units per tap, clipped to the field
    function automatic logic [FINE_W-1:0] fine_of(input phase_t code);
        logic [FINE_W:0] dbl;
        dbl = {ones16(code), 1'b0};
        return (dbl > 6'd31) ? '1 : dbl[FINE_W-1:0];
    endfunction

    function automatic int_t sat_int(input logic [4:0] n);
        return (n > 5'd15) ? '1 : n[INT_W-1:0];
    endfunction

    // ----------------------------------------
    // hit stepping
    assign step    = run || (hit.window_done && (hit.hit_count != '0));
    assign sel     = run ? idx : '0;
    assign is_last = (sel == hit.hit_count - 1'b1) || (sel == LAST_SLOT);

    assign fine_start = fine_of(hit.start_code);
    assign fine_stop  = fine_of(hit.hit_code[sel]);
    assign tof_c      = {hit.hit_coarse[sel], {FINE_W{1'b0}}}
                      + tof_t'(fine_stop) - tof_t'(fine_start);   // wraps mod 2^15
    assign int_c      = sat_int(ones16(hit.hit_mask[sel]));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            run           <= 1'b0;
            idx           <= '0;
            last_q        <= 1'b0;
            res.res_valid <= 1'b0;
            res.res_ready <= 1'b0;
        end else begin
            res.res_valid <= step;
            last_q        <= step && is_last;
            // empty window reports at once
            res.res_ready <= last_q || (hit.window_done && (hit.hit_count == '0));
            if (step) begin
                run <= !is_last;
                idx <= sel + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (step) begin
            res.res_idx <= sel;
            res.res_tof <= tof_c;
            res.res_int <= int_c;
        end
        if (hit.window_done) begin
            res.res_count <= hit.hit_count;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/tdc_top.sv ====
`default_nettype none
`timescale 1ns/100ps

module tdc_top #(
    parameter int N_HITS = tdc_pkg::MAX_HITS    // 1 to 3
) (
    input  wire logic              clk,
    input  wire logic              rst_n,
    input  wire logic              tdc_start_i,
    input  wire tdc_pkg::phase_t   start_code_i,
    input  wire tdc_pkg::tof_t     range_i,
    input  wire logic              tdc_trigger_i,
    input  wire tdc_pkg::phase_t   stop_code_i,
    input  wire logic [15:0]       spad_mask_i,
    output tdc_pkg::tof_t          out_data_o,
    output tdc_pkg::int_t          out_int_o,
    output tdc_pkg::hit_idx_t      out_num_o,
    output logic                   out_last_o,
    output logic                   out_valid_o,
    input  wire logic              out_ready_i,
    output logic                   busy_o
);

    tdc_hit_if #(.N_HITS(N_HITS)) hit_bus ();
    tdc_res_if                    res_bus ();

    tdc_hit_capture #(.N_HITS(N_HITS)) hit_capture_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .tdc_start_i   (tdc_start_i),
        .start_code_i  (start_code_i),
        .range_i       (range_i),
        .tdc_trigger_i (tdc_trigger_i),
        .stop_code_i   (stop_code_i),
        .spad_mask_i   (spad_mask_i),
        .burst_done_i  (res_bus.burst_done),   // closes the measurement
        .busy_o        (busy_o),
        .hit           (hit_bus.capture)
    );

    tdc_tof_calc #(.N_HITS(N_HITS)) tof_calc_i (
        .clk   (clk),
        .rst_n (rst_n),
        .hit   (hit_bus.calc),
        .res   (res_bus.calc)
    );

    tdc_burst_out #(.N_HITS(N_HITS)) burst_out_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .res         (res_bus.result),
        .out_data_o  (out_data_o),
        .out_int_o   (out_int_o),
        .out_num_o   (out_num_o),
        .out_last_o  (out_last_o),
        .out_valid_o (out_valid_o),
        .out_ready_i (out_ready_i)
    );

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# build and run the TDC testbench with Verilator
cd "$(dirname "$0")" &&
rm -f sim.log &&
verilator --binary --timing --assert -Wno-fatal --top-module tdc_tb \
    -f flist.f -o sim_tdc &&
{ ./obj_dir/sim_tdc > sim.log 2>&1 || true; } &&
grep -q "TESTBENCH PASSED" sim.log &&
echo "simulation ok, see sim.log" ||
{ echo "simulation failed, see sim.log"; exit 1; }
